// File: chroni_pkg.sv
`default_nettype none

package chroni_pkg;

   // register window at 0x9000..0x907f
   localparam logic [8:0] reg_base = 9'h120;

   localparam logic [6:0] reg_dl_lo       = 7'h00;
   localparam logic [6:0] reg_dl_hi       = 7'h01;
   localparam logic [6:0] reg_pal_index   = 7'h04;
   localparam logic [6:0] reg_pal_data    = 7'h05;
   localparam logic [6:0] reg_vaddr_lo    = 7'h06;
   localparam logic [6:0] reg_vaddr_hi    = 7'h07;
   localparam logic [6:0] reg_vaddr_top   = 7'h08;
   localparam logic [6:0] reg_vdata       = 7'h09;
   localparam logic [6:0] reg_vaux_lo     = 7'h0a;
   localparam logic [6:0] reg_vaux_hi     = 7'h0b;
   localparam logic [6:0] reg_vaux_top    = 7'h0c;
   localparam logic [6:0] reg_vauxdata    = 7'h0d;
   localparam logic [6:0] reg_status      = 7'h12;
   localparam logic [6:0] reg_vpage_lo    = 7'h26;
   localparam logic [6:0] reg_vpage_hi    = 7'h27;
   localparam logic [6:0] reg_vauxpage_lo = 7'h28;
   localparam logic [6:0] reg_vauxpage_hi = 7'h29;

   localparam int vram_aw    = 16;
   localparam int vram_dw    = 16;
   localparam int byte_ptr_w = 17; // byte address into word memory
   localparam int pal_aw     = 8;
   localparam int pal_dw     = 16;

   // display list instruction modes, bits 11:8
   localparam logic [3:0] mode_blank  = 4'd0;
   localparam logic [3:0] mode_text80 = 4'd1;
   localparam logic [3:0] mode_text40 = 4'd2;
   localparam logic [3:0] mode_tile   = 4'd3;
   localparam logic [3:0] mode_end    = 4'd15;

   localparam logic [7:0] cols_text80_wide   = 8'd80;
   localparam logic [7:0] cols_text80_narrow = 8'd64;
   localparam logic [7:0] cols_40_wide       = 8'd40; // text40 and tile
   localparam logic [7:0] cols_40_narrow     = 8'd32;

   typedef struct packed {
      logic               en;
      logic [vram_aw-1:0] addr;
      logic [1:0]         byte_en;
      logic [vram_dw-1:0] data;
   } vram_wr_t;

   typedef struct packed {
      logic              en;
      logic [pal_aw-1:0] addr;
      logic [pal_dw-1:0] data;
   } pal_wr_t;

   typedef struct packed {
      logic        blank;
      logic [3:0]  mode;
      logic [15:0] lms;
      logic [15:0] attr;
      logic [7:0]  cols;
      logic [7:0]  row;
   } line_desc_t;

endpackage

`default_nettype wire

// File: chroni_regs.sv
`timescale 1ns/1ps
`default_nettype none

module chroni_regs import chroni_pkg::*; (
   input  wire             sys_clk,
   input  wire             reset_n,
   input  wire [15:0]      cpu_addr,
   input  wire [7:0]       cpu_wr_data,
   input  wire             cpu_wr_en,
   input  wire             v_blank,
   output logic [7:0]      cpu_rd_data,
   output vram_wr_t        vram_wr,
   output logic            pal_index_wr,
   output logic            pal_data_wr,
   output logic [7:0]      pal_byte,
   output logic [15:0]     display_list_addr,
   output logic            irq
);

   typedef enum logic [2:0] {
      ptr_none, ptr_lo, ptr_hi, ptr_top, ptr_data, ptr_page_lo, ptr_page_hi
   } ptr_op_e;

   logic                  wr_en_q;
   logic                  reg_cs;
   logic                  wr_hit;
   logic [6:0]            offset;
   logic [byte_ptr_w-1:0] main_ptr;
   logic [byte_ptr_w-1:0] aux_ptr;
   ptr_op_e               main_op;
   ptr_op_e               aux_op;
   logic                  irq_en;
   logic                  vblank_fired;

   // pointer update shared by main and aux
   function automatic logic [byte_ptr_w-1:0] ptr_next(input logic [byte_ptr_w-1:0] ptr,
                                                      input ptr_op_e op,
                                                      input logic [7:0] d);
      logic [byte_ptr_w-1:0] nxt;
      nxt = ptr;
      case (op)
         ptr_lo:      nxt[7:0]  = d;
         ptr_hi:      nxt[15:8] = d;
         ptr_top:     nxt[16]   = d[0];
         ptr_data:    nxt       = ptr + 1'b1;
         ptr_page_lo: nxt[8:0]  = {d, 1'b0}; // pages are word aligned
         ptr_page_hi: nxt[16:9] = d;
         default:     nxt       = ptr;
      endcase
      return nxt;
   endfunction

   assign reg_cs = cpu_addr[15:7] == reg_base;
   assign offset = cpu_addr[6:0];
   assign wr_hit = reg_cs && cpu_wr_en && !wr_en_q; // rising edge only

   always_comb begin
      main_op = ptr_none;
      aux_op  = ptr_none;
      if (wr_hit) begin
         case (offset)
            reg_vaddr_lo:    main_op = ptr_lo;
            reg_vaddr_hi:    main_op = ptr_hi;
            reg_vaddr_top:   main_op = ptr_top;
            reg_vdata:       main_op = ptr_data;
            reg_vpage_lo:    main_op = ptr_page_lo;
            reg_vpage_hi:    main_op = ptr_page_hi;
            reg_vaux_lo:     aux_op  = ptr_lo;
            reg_vaux_hi:     aux_op  = ptr_hi;
            reg_vaux_top:    aux_op  = ptr_top;
            reg_vauxdata:    aux_op  = ptr_data;
            reg_vauxpage_lo: aux_op  = ptr_page_lo;
            reg_vauxpage_hi: aux_op  = ptr_page_hi;
            default: ;
         endcase
      end
   end

   assign pal_index_wr = wr_hit && offset == reg_pal_index;
   assign pal_data_wr  = wr_hit && offset == reg_pal_data;
   assign pal_byte     = cpu_wr_data;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         wr_en_q           <= 1'b0;
         main_ptr          <= '0;
         aux_ptr           <= '0;
         display_list_addr <= '0;
         irq_en            <= 1'b0;
         vblank_fired      <= 1'b0;
         vram_wr.en        <= 1'b0;
      end else begin
         wr_en_q      <= cpu_wr_en;
         vblank_fired <= v_blank;
         main_ptr     <= ptr_next(main_ptr, main_op, cpu_wr_data);
         aux_ptr      <= ptr_next(aux_ptr, aux_op, cpu_wr_data);
         vram_wr.en   <= main_op == ptr_data || aux_op == ptr_data;
         if (wr_hit && offset == reg_dl_lo)
            display_list_addr[7:0] <= cpu_wr_data;
         if (wr_hit && offset == reg_dl_hi)
            display_list_addr[15:8] <= cpu_wr_data;
         if (wr_hit && offset == reg_status)
            irq_en <= cpu_wr_data[2];
      end
   end

   // write payload, odd pointer hits the high byte only
   always_ff @(posedge sys_clk) begin
      if (main_op == ptr_data) begin
         vram_wr.addr    <= main_ptr[byte_ptr_w-1:1];
         vram_wr.byte_en <= main_ptr[0] ? 2'b10 : 2'b11;
      end else begin
         vram_wr.addr    <= aux_ptr[byte_ptr_w-1:1];
         vram_wr.byte_en <= aux_ptr[0] ? 2'b10 : 2'b11;
      end
      vram_wr.data <= {cpu_wr_data, cpu_wr_data};
   end

   always_ff @(posedge sys_clk) begin
      if (reg_cs) begin
         case (offset)
            reg_dl_lo:       cpu_rd_data <= display_list_addr[7:0];
            reg_dl_hi:       cpu_rd_data <= display_list_addr[15:8];
            reg_vaddr_lo:    cpu_rd_data <= main_ptr[7:0];
            reg_vaddr_hi:    cpu_rd_data <= main_ptr[15:8];
            reg_vaddr_top:   cpu_rd_data <= {7'd0, main_ptr[16]};
            reg_vaux_lo:     cpu_rd_data <= aux_ptr[7:0];
            reg_vaux_hi:     cpu_rd_data <= aux_ptr[15:8];
            reg_vaux_top:    cpu_rd_data <= {7'd0, aux_ptr[16]};
            reg_status:      cpu_rd_data <= {vblank_fired, 4'd0, irq_en, 2'd0};
            reg_vpage_lo:    cpu_rd_data <= main_ptr[8:1];
            reg_vpage_hi:    cpu_rd_data <= main_ptr[16:9];
            reg_vauxpage_lo: cpu_rd_data <= aux_ptr[8:1];
            reg_vauxpage_hi: cpu_rd_data <= aux_ptr[16:9];
            default:         cpu_rd_data <= cpu_rd_data; // unmapped keeps last value
         endcase
      end
   end

   assign irq = vblank_fired && irq_en;

endmodule

`default_nettype wire

// File: chroni_palette.sv
`timescale 1ns/1ps
`default_nettype none

module chroni_palette import chroni_pkg::*; (
   input  wire              sys_clk,
   input  wire              reset_n,
   input  wire              pal_index_wr,
   input  wire              pal_data_wr,
   input  wire [7:0]        pal_byte,
   input  wire [pal_aw-1:0] pal_rd_addr,
   output logic [pal_dw-1:0] pal_rd_data
);

   typedef enum logic [1:0] {st_lo, st_hi, st_commit} pal_state_e;

   pal_state_e        state;
   logic [pal_aw-1:0] index;
   logic [pal_dw-1:0] value;
   pal_wr_t           pal_wr;
   logic [pal_dw-1:0] mem [2**pal_aw];

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         state <= st_lo;
         index <= '0;
      end else if (pal_index_wr) begin
         index <= pal_byte;
         state <= st_lo;
      end else if (pal_data_wr) begin
         if (state == st_lo) begin
            value[7:0] <= pal_byte;
            state      <= st_hi;
         end else begin
            value[15:8] <= pal_byte;
            state       <= st_commit;
         end
      end else if (state == st_commit) begin
         index <= index + 1'b1; // next entry
         state <= st_lo;
      end
   end

   assign pal_wr.en   = state == st_commit && !pal_index_wr && !pal_data_wr;
   assign pal_wr.addr = index;
   assign pal_wr.data = value;

   always_ff @(posedge sys_clk) begin
      if (pal_wr.en)
         mem[pal_wr.addr] <= pal_wr.data;
      pal_rd_data <= mem[pal_rd_addr];
   end

endmodule

`default_nettype wire

// File: chroni_vram.sv
`timescale 1ns/1ps
`default_nettype none

module chroni_vram import chroni_pkg::*; (
   input  wire                sys_clk,
   input  wire vram_wr_t      vram_wr,
   input  wire [vram_aw-1:0]  dl_rd_addr,
   output logic [vram_dw-1:0] dl_rd_data
);

   logic [vram_dw-1:0] mem [2**vram_aw];

   // port a takes cpu writes with byte enables
   always_ff @(posedge sys_clk) begin
      if (vram_wr.en) begin
         for (int b = 0; b < vram_dw / 8; b++) begin
            if (vram_wr.byte_en[b])
               mem[vram_wr.addr][b*8 +: 8] <= vram_wr.data[b*8 +: 8];
         end
      end
   end

   // port b is a registered read for the display list
   always_ff @(posedge sys_clk) begin
      dl_rd_data <= mem[dl_rd_addr];
   end

endmodule

`default_nettype wire

// File: chroni_dlist.sv
`timescale 1ns/1ps
`default_nettype none

module chroni_dlist import chroni_pkg::*; (
   input  wire                sys_clk,
   input  wire                reset_n,
   input  wire                frame_start,
   input  wire                scanline_start,
   input  wire [15:0]         display_list_addr,
   input  wire [vram_dw-1:0]  dl_rd_data,
   output logic [vram_aw-1:0] dl_rd_addr,
   output logic               line_valid,
   output line_desc_t         line_desc
);

   typedef enum logic [2:0] {
      st_idle, st_read, st_read_wait, st_addr_read, st_addr_wait, st_exec
   } dl_state_e;

   dl_state_e    state;
   logic [15:0]  ptr;
   logic [7:0]   count;   // lines left in current instruction
   logic [7:0]   row;
   logic [3:0]   mode;
   logic         narrow;
   logic [15:0]  lms;
   logic [15:0]  attr;
   logic         addr_part; // 0 lms, 1 attr
   logic         ended;

   function automatic logic [7:0] mode_cols(input logic [3:0] m, input logic nar);
      case (m)
         mode_text80:           return nar ? cols_text80_narrow : cols_text80_wide;
         mode_text40, mode_tile: return nar ? cols_40_narrow : cols_40_wide;
         default:               return 8'd0;
      endcase
   endfunction

   // modes that carry an lms word after the instruction
   function automatic logic has_lms(input logic [3:0] m);
      return m == mode_text80 || m == mode_text40 || m == mode_tile;
   endfunction

   assign dl_rd_addr = ptr; // memory samples the pointer every cycle

   always_ff @(posedge sys_clk) begin
      if (!reset_n || frame_start) begin
         state      <= st_idle;
         ptr        <= display_list_addr;
         count      <= '0;
         row        <= '0;
         mode       <= mode_blank;
         narrow     <= 1'b0;
         addr_part  <= 1'b0;
         ended      <= 1'b0;
         line_valid <= 1'b0;
      end else begin
         line_valid <= 1'b0;
         case (state)
            st_idle: begin
               if (scanline_start) begin
                  if (ended) begin
                     state <= st_exec;
                  end else if (count != 0) begin
                     count <= count - 1'b1;
                     row   <= row + 1'b1;
                     state <= st_exec;
                  end else begin
                     state <= st_read;
                  end
               end
            end
            st_read: begin
               ptr   <= ptr + 1'b1;
               state <= st_read_wait;
            end
            st_read_wait: begin
               narrow    <= dl_rd_data[12]; // bit 13 scroll is ignored
               mode      <= dl_rd_data[11:8];
               count     <= dl_rd_data[7:0] - 1'b1;
               row       <= '0;
               lms       <= '0;
               attr      <= '0;
               addr_part <= 1'b0;
               ended     <= dl_rd_data[11:8] == mode_end;
               state     <= has_lms(dl_rd_data[11:8]) ? st_addr_read : st_exec;
            end
            st_addr_read: begin
               ptr   <= ptr + 1'b1;
               state <= st_addr_wait;
            end
            st_addr_wait: begin
               if (!addr_part)
                  lms <= dl_rd_data;
               else
                  attr <= dl_rd_data;
               if (!addr_part && mode != mode_tile) begin
                  addr_part <= 1'b1;
                  state     <= st_addr_read;
               end else begin
                  state <= st_exec;
               end
            end
            st_exec: begin
               line_valid <= 1'b1;
               state      <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (state == st_exec) begin
         line_desc.blank <= !has_lms(mode);
         line_desc.mode  <= mode;
         line_desc.lms   <= lms;
         line_desc.attr  <= attr;
         line_desc.cols  <= mode_cols(mode, narrow);
         line_desc.row   <= row;
      end
   end

endmodule

`default_nettype wire

// File: chroni_top.sv
`timescale 1ns/1ps
`default_nettype none

module chroni_top import chroni_pkg::*; (
   input  wire               sys_clk,
   input  wire               reset_n,
   input  wire [15:0]        cpu_addr,
   input  wire [7:0]         cpu_wr_data,
   input  wire               cpu_wr_en,
   output logic [7:0]        cpu_rd_data,
   input  wire               frame_start,
   input  wire               scanline_start,
   input  wire               v_blank,
   input  wire [pal_aw-1:0]  pal_rd_addr,
   output logic [pal_dw-1:0] pal_rd_data,
   output logic              line_valid,
   output line_desc_t        line_desc,
   output logic              irq
);

   vram_wr_t           vram_wr;
   logic               pal_index_wr;
   logic               pal_data_wr;
   logic [7:0]         pal_byte;
   logic [15:0]        display_list_addr;
   logic [vram_aw-1:0] dl_rd_addr;
   logic [vram_dw-1:0] dl_rd_data;

   chroni_regs i_regs (
      .sys_clk           (sys_clk),
      .reset_n           (reset_n),
      .cpu_addr          (cpu_addr),
      .cpu_wr_data       (cpu_wr_data),
      .cpu_wr_en         (cpu_wr_en),
      .v_blank           (v_blank),
      .cpu_rd_data       (cpu_rd_data),
      .vram_wr           (vram_wr),
      .pal_index_wr      (pal_index_wr),
      .pal_data_wr       (pal_data_wr),
      .pal_byte          (pal_byte),
      .display_list_addr (display_list_addr),
      .irq               (irq)
   );

   chroni_palette i_palette (
      .sys_clk      (sys_clk),
      .reset_n      (reset_n),
      .pal_index_wr (pal_index_wr),
      .pal_data_wr  (pal_data_wr),
      .pal_byte     (pal_byte),
      .pal_rd_addr  (pal_rd_addr),
      .pal_rd_data  (pal_rd_data)
   );

   chroni_vram i_vram (
      .sys_clk    (sys_clk),
      .vram_wr    (vram_wr),
      .dl_rd_addr (dl_rd_addr),
      .dl_rd_data (dl_rd_data)
   );

   chroni_dlist i_dlist (
      .sys_clk           (sys_clk),
      .reset_n           (reset_n),
      .frame_start       (frame_start),
      .scanline_start    (scanline_start),
      .display_list_addr (display_list_addr),
      .dl_rd_data        (dl_rd_data),
      .dl_rd_addr        (dl_rd_addr),
      .line_valid        (line_valid),
      .line_desc         (line_desc)
   );

endmodule

`default_nettype wire

// File: tb_chroni_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_chroni_checker import chroni_pkg::*; (
   input  wire               sys_clk,
   input  wire               rd_chk,
   input  wire               pal_chk,
   input  wire               irq_chk,
   input  wire               line_chk,
   input  wire [159:0]       test_name,
   input  wire [63:0]        expected,
   input  wire [7:0]         cpu_rd_data,
   input  wire [pal_dw-1:0]  pal_rd_data,
   input  wire               irq,
   input  wire               line_valid,
   input  wire line_desc_t   line_desc,
   output logic              line_busy,
   output int                pass_count,
   output int                fail_count
);

   logic [63:0]  line_exp;
   logic [159:0] line_name;
   int           wait_cycles;

   task automatic compare(input logic [159:0] nm, input logic [63:0] exp,
                          input logic [63:0] act);
      if (exp == act) begin
         pass_count++;
         $display("Pass %0s", nm);
      end else begin
         fail_count++;
         $display("Fail %0s expected %h actual %h", nm, exp, act);
      end
   endtask

   initial begin
      pass_count = 0;
      fail_count = 0;
      line_busy <= 1'b0;
   end

   // values are taken at the edge before the dut updates them
   always @(posedge sys_clk) begin
      if (rd_chk)
         compare(test_name, expected, {56'd0, cpu_rd_data});
      if (pal_chk)
         compare(test_name, expected, {48'd0, pal_rd_data});
      if (irq_chk)
         compare(test_name, expected, {63'd0, irq});
      if (line_busy) begin
         if (line_valid) begin
            compare(line_name, line_exp, {11'd0, line_desc});
            line_busy <= 1'b0;
         end else if (wait_cycles >= 32) begin
            fail_count++;
            $display("Fail %0s: no line_valid arrived within 32 cycles", line_name);
            line_busy <= 1'b0;
         end else begin
            wait_cycles <= wait_cycles + 1;
         end
      end
      if (line_chk) begin // arm a wait for the next descriptor
         line_busy   <= 1'b1;
         line_exp    <= expected;
         line_name   <= test_name;
         wait_cycles <= 0;
      end
   end

endmodule

`default_nettype wire

// File: tb_chroni.sv
`timescale 1ns/1ps
`default_nettype none

module tb_chroni import chroni_pkg::*; ();

   localparam int max_entries = 128;

   typedef enum logic [2:0] {k_wr, k_rd, k_pal, k_scan, k_frame, k_vblank, k_irq} kind_e;

   logic               sys_clk;
   logic               reset_n;
   logic [15:0]        cpu_addr;
   logic [7:0]         cpu_wr_data;
   logic               cpu_wr_en;
   logic [7:0]         cpu_rd_data;
   logic               frame_start;
   logic               scanline_start;
   logic               v_blank;
   logic [pal_aw-1:0]  pal_rd_addr;
   logic [pal_dw-1:0]  pal_rd_data;
   logic               line_valid;
   line_desc_t         line_desc;
   logic               irq;
   logic               rd_chk;
   logic               pal_chk;
   logic               irq_chk;
   logic               line_chk;
   logic [159:0]       chk_name;
   logic [63:0]        chk_exp;
   logic               line_busy;
   int                 pass_count;
   int                 fail_count;

   logic [159:0] t_name [max_entries];
   kind_e        t_kind [max_entries];
   logic [15:0]  t_addr [max_entries];
   logic [15:0]  t_data [max_entries];
   logic [63:0]  t_exp  [max_entries];
   int           table_len = 0;
   logic         table_ready = 1'b0;

   chroni_top i_chroni_top (
      .sys_clk(sys_clk), .reset_n(reset_n), .cpu_addr(cpu_addr), .cpu_wr_data(cpu_wr_data),
      .cpu_wr_en(cpu_wr_en), .cpu_rd_data(cpu_rd_data), .frame_start(frame_start),
      .scanline_start(scanline_start), .v_blank(v_blank), .pal_rd_addr(pal_rd_addr),
      .pal_rd_data(pal_rd_data), .line_valid(line_valid), .line_desc(line_desc), .irq(irq)
   );

   tb_chroni_checker i_checker (
      .sys_clk(sys_clk), .rd_chk(rd_chk), .pal_chk(pal_chk), .irq_chk(irq_chk),
      .line_chk(line_chk), .test_name(chk_name), .expected(chk_exp),
      .cpu_rd_data(cpu_rd_data), .pal_rd_data(pal_rd_data), .irq(irq),
      .line_valid(line_valid), .line_desc(line_desc), .line_busy(line_busy),
      .pass_count(pass_count), .fail_count(fail_count)
   );

   initial begin
      sys_clk = 1'b0;
      forever #20 sys_clk = ~sys_clk;
   end

   task automatic add(input logic [159:0] nm, input kind_e k, input logic [15:0] a,
                      input logic [15:0] d, input logic [63:0] e);
      t_name[table_len] = nm;
      t_kind[table_len] = k;
      t_addr[table_len] = a;
      t_data[table_len] = d;
      t_exp[table_len]  = e;
      table_len++;
   endtask

   task automatic reg_wr(input logic [6:0] off, input logic [7:0] d);
      add("write", k_wr, {reg_base, off}, {8'd0, d}, 64'd0);
   endtask

   task automatic reg_rd(input logic [159:0] nm, input logic [6:0] off, input logic [7:0] e);
      add(nm, k_rd, {reg_base, off}, 16'd0, {56'd0, e});
   endtask

   task automatic put_word(input logic [15:0] w); // even byte first
      reg_wr(reg_vdata, w[7:0]);
      reg_wr(reg_vdata, w[15:8]);
   endtask

   function automatic logic [63:0] desc(input logic b, input logic [3:0] m,
                                        input logic [15:0] l, input logic [15:0] a,
                                        input logic [7:0] c, input logic [7:0] r);
      return {11'd0, b, m, l, a, c, r};
   endfunction

   task automatic build_table();
      logic [15:0] dl_word;
      logic [7:0]  idx;
      logic [7:0]  lo [3];
      logic [7:0]  hi [3];
      logic [16:0] mptr;
      logic [16:0] aptr;
      dl_word = 16'h0100 + {4'd0, 12'($urandom)};
      reg_wr(reg_dl_lo, dl_word[7:0]);
      reg_wr(reg_dl_hi, dl_word[15:8]);
      reg_rd("dl_lo", reg_dl_lo, dl_word[7:0]);
      reg_rd("dl_hi", reg_dl_hi, dl_word[15:8]);
      mptr = 17'h11234;
      reg_wr(reg_vaddr_lo, mptr[7:0]);
      reg_wr(reg_vaddr_hi, mptr[15:8]);
      reg_wr(reg_vaddr_top, {7'd0, mptr[16]});
      reg_rd("vaddr_lo", reg_vaddr_lo, mptr[7:0]);
      reg_rd("vaddr_hi", reg_vaddr_hi, mptr[15:8]);
      reg_rd("vaddr_top", reg_vaddr_top, {7'd0, mptr[16]});
      reg_rd("vpage_lo", reg_vpage_lo, mptr[8:1]);
      reg_rd("vpage_hi", reg_vpage_hi, mptr[16:9]);
      reg_wr(reg_vdata, 8'h5a);
      mptr = mptr + 17'd1;
      reg_rd("vaddr_lo after data", reg_vaddr_lo, mptr[7:0]);
      aptr = {8'h9a, 8'h56, 1'b0};
      reg_wr(reg_vauxpage_lo, 8'h56);
      reg_wr(reg_vauxpage_hi, 8'h9a);
      reg_rd("vaux_lo", reg_vaux_lo, aptr[7:0]);
      reg_rd("vaux_hi", reg_vaux_hi, aptr[15:8]);
      reg_rd("vaux_top", reg_vaux_top, {7'd0, aptr[16]});
      reg_rd("vauxpage_lo", reg_vauxpage_lo, aptr[8:1]);
      reg_rd("vauxpage_hi", reg_vauxpage_hi, aptr[16:9]);
      reg_wr(reg_vauxdata, 8'ha5);
      aptr = aptr + 17'd1;
      reg_rd("vaux_lo after data", reg_vaux_lo, aptr[7:0]);
      aptr = 17'h03ec7;
      reg_wr(reg_vaux_lo, aptr[7:0]);
      reg_wr(reg_vaux_hi, aptr[15:8]);
      reg_wr(reg_vaux_top, {7'd0, aptr[16]});
      reg_rd("vaux_lo byte form", reg_vaux_lo, 8'hc7);
      reg_rd("vaux_hi byte form", reg_vaux_hi, 8'h3e);
      reg_rd("vaux_top byte form", reg_vaux_top, 8'h00);
      // three palette entries from a random index
      idx = 8'($urandom % 253);
      reg_wr(reg_pal_index, idx);
      for (int k = 0; k < 3; k++) begin
         lo[k] = 8'($urandom);
         hi[k] = 8'($urandom);
         reg_wr(reg_pal_data, lo[k]);
         reg_wr(reg_pal_data, hi[k]);
      end
      for (int k = 0; k < 3; k++)
         add("palette entry", k_pal, {8'd0, idx + 8'(k)}, 16'd0, {48'd0, hi[k], lo[k]});
      reg_wr(reg_vpage_lo, dl_word[7:0]);
      reg_wr(reg_vpage_hi, dl_word[15:8]);
      reg_rd("dl page lo", reg_vpage_lo, dl_word[7:0]);
      reg_rd("dl page hi", reg_vpage_hi, dl_word[15:8]);
      reg_rd("dl page byte lo", reg_vaddr_lo, {dl_word[6:0], 1'b0});
      put_word(16'h0102); // text80 wide with 2 lines
      put_word(16'h2000);
      put_word(16'h3000);
      put_word(16'h1301); // tile narrow with 1 line
      put_word(16'h4000);
      put_word(16'h0001);
      put_word(16'h0f01);
      add("frame", k_frame, 16'd0, 16'd0, 64'd0);
      add("text80 row 0", k_scan, 0, 0, desc(0, mode_text80, 16'h2000, 16'h3000, 80, 0));
      add("text80 row 1", k_scan, 0, 0, desc(0, mode_text80, 16'h2000, 16'h3000, 80, 1));
      add("tile narrow", k_scan, 0, 0, desc(0, mode_tile, 16'h4000, 16'h0000, 32, 0));
      add("blank line", k_scan, 0, 0, desc(1, mode_blank, 16'h0, 16'h0, 0, 0));
      add("end of list", k_scan, 0, 0, desc(1, mode_end, 16'h0, 16'h0, 0, 0));
      add("after end", k_scan, 0, 0, desc(1, mode_end, 16'h0, 16'h0, 0, 0));
      add("frame", k_frame, 16'd0, 16'd0, 64'd0);
      add("restart", k_scan, 0, 0, desc(0, mode_text80, 16'h2000, 16'h3000, 80, 0));
      // vertical interrupt
      add("vblank high", k_vblank, 16'd0, 16'd1, 64'd0);
      add("irq masked", k_irq, 16'd0, 16'd0, 64'd0);
      reg_rd("status fired", reg_status, 8'h80);
      reg_wr(reg_status, 8'h04);
      add("irq enabled", k_irq, 16'd0, 16'd0, 64'd1);
      reg_rd("status fired enabled", reg_status, 8'h84);
      add("vblank low", k_vblank, 16'd0, 16'd0, 64'd0);
      add("irq cleared", k_irq, 16'd0, 16'd0, 64'd0);
      reg_rd("status cleared", reg_status, 8'h04);
   endtask

   task automatic run_entry(input int i);
      chk_name = t_name[i];
      chk_exp  = t_exp[i];
      case (t_kind[i])
         k_wr: begin
            cpu_addr    = t_addr[i];
            cpu_wr_data = t_data[i][7:0];
            cpu_wr_en   = 1'b1;
            @(posedge sys_clk);
            #2;
            cpu_wr_en = 1'b0;
         end
         k_rd, k_pal: begin
            if (t_kind[i] == k_rd)
               cpu_addr = t_addr[i];
            else
               pal_rd_addr = t_addr[i][7:0];
            @(posedge sys_clk);
            #2;
            rd_chk  = t_kind[i] == k_rd;
            pal_chk = t_kind[i] == k_pal;
            @(posedge sys_clk);
            #2;
            rd_chk  = 1'b0;
            pal_chk = 1'b0;
         end
         k_irq: begin
            irq_chk = 1'b1;
            @(posedge sys_clk);
            #2;
            irq_chk = 1'b0;
         end
         k_scan: begin
            scanline_start = 1'b1;
            line_chk       = 1'b1;
            @(posedge sys_clk);
            #2;
            scanline_start = 1'b0;
            line_chk       = 1'b0;
            while (line_busy) begin // checker gives up after 32 cycles
               @(posedge sys_clk);
               #2;
            end
         end
         k_frame: begin
            frame_start = 1'b1;
            @(posedge sys_clk);
            #2;
            frame_start = 1'b0;
         end
         default: v_blank = t_data[i][0];
      endcase
      @(posedge sys_clk);
      #2;
   endtask

   initial begin
      reset_n        = 1'b0;
      cpu_addr       = 16'd0;
      cpu_wr_data    = 8'd0;
      cpu_wr_en      = 1'b0;
      frame_start    = 1'b0;
      scanline_start = 1'b0;
      v_blank        = 1'b0;
      pal_rd_addr    = '0;
      rd_chk         = 1'b0;
      pal_chk        = 1'b0;
      irq_chk        = 1'b0;
      line_chk       = 1'b0;
      chk_name       = '0;
      chk_exp        = '0;
      void'($urandom(32'h9bd4));
      build_table();
      table_ready = 1'b1;
      repeat (4) @(posedge sys_clk);
      #2;
      reset_n = 1'b1;
      for (int i = 0; i < table_len; i++)
         run_entry(i);
      repeat (2) @(posedge sys_clk);
      $display("%0d checks passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   initial begin
      wait (table_ready);
      #(table_len * 64 * 40);
      $display("watchdog timeout, the run did not finish in time");
      $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
chroni_pkg.sv
chroni_regs.sv
chroni_palette.sv
chroni_vram.sv
chroni_dlist.sv
chroni_top.sv
tb_chroni_checker.sv
tb_chroni.sv

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_chroni -o tb_chroni
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/tb_chroni)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
   exit 0
fi
exit 1
